/* Makefile */
VERILATOR ?= verilator
TOP ?= cdc_tb
OBJ_DIR ?= obj_dir
FILE_LIST ?= list.f
VFLAGS ?= --binary --timing --assert --timescale 1ns/1ps -j 0
PASS_MSG := *** TEST PASSED ***

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator, run the testbench, look for the pass message"
	@echo "  clean  remove the build directory"
	@echo "Variables: VERILATOR TOP OBJ_DIR FILE_LIST VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILE_LIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) | tee /dev/stderr | grep -F '$(PASS_MSG)' > /dev/null

clean:
	rm -rf $(OBJ_DIR)

/* design/bit_sync.sv */
`default_nettype none
`include "cdc_defs.svh"

module bit_sync #(
	parameter int STAGES = `SYNC_STAGES
) (
	input  logic clk,
	input  logic rst_n,
	input  logic d,
	output logic q
);

	logic [STAGES-1:0] sync_q;

	// First stage may go metastable, later stages settle it
	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
			sync_q <= '0;
		else
			sync_q <= {sync_q[STAGES-2:0], d};
	end

	assign q = sync_q[STAGES-1];

endmodule

`default_nettype wire

/* design/cdc_channel.sv */
`default_nettype none
`include "cdc_defs.svh"

module cdc_channel #(
	parameter int WIDTH = 32
) (
	input  logic             src_clk,
	input  logic             dst_clk,
	input  logic             rst_n,
	input  logic [WIDTH-1:0] data_in,
	input  logic             valid_in,
	output logic             rdy,
	output logic             done,
	output logic [WIDTH-1:0] data_out,
	output logic             valid_out
);

	logic [1:0] src_rst_q;
	logic [1:0] dst_rst_q;
	logic src_rst_n;
	logic dst_rst_n;
	wire xfer_pkg::hs_t hs;
	logic req_sync;
	logic ack_sync;
	logic [WIDTH-1:0] data_hold;

	// Asserted asynchronously, released on the local clock
	always_ff @(posedge src_clk or negedge rst_n)
	begin
		if (!rst_n)
			src_rst_q <= 2'b00;
		else
			src_rst_q <= {src_rst_q[0], 1'b1};
	end

	always_ff @(posedge dst_clk or negedge rst_n)
	begin
		if (!rst_n)
			dst_rst_q <= 2'b00;
		else
			dst_rst_q <= {dst_rst_q[0], 1'b1};
	end

	assign src_rst_n = src_rst_q[1];
	assign dst_rst_n = dst_rst_q[1];

	xfer_src #(
		.WIDTH(WIDTH)
	) i_src (
		.clk      (src_clk),
		.rst_n    (src_rst_n),
		.data_in  (data_in),
		.valid_in (valid_in),
		.ack_sync (ack_sync),
		.req      (hs.req),
		.data_hold(data_hold),
		.rdy      (rdy),
		.done     (done)
	);

	// req into the destination domain
	bit_sync #(
		.STAGES(`SYNC_STAGES)
	) i_req_sync (
		.clk  (dst_clk),
		.rst_n(dst_rst_n),
		.d    (hs.req),
		.q    (req_sync)
	);

	// ack back into the source domain
	bit_sync #(
		.STAGES(`SYNC_STAGES)
	) i_ack_sync (
		.clk  (src_clk),
		.rst_n(src_rst_n),
		.d    (hs.ack),
		.q    (ack_sync)
	);

	xfer_dst #(
		.WIDTH(WIDTH)
	) i_dst (
		.clk      (dst_clk),
		.rst_n    (dst_rst_n),
		.req_sync (req_sync),
		.data_hold(data_hold),
		.data_out (data_out),
		.valid_out(valid_out),
		.ack      (hs.ack)
	);

endmodule

`default_nettype wire

/* design/cdc_defs.svh */
`ifndef CDC_DEFS_SVH
`define CDC_DEFS_SVH

// Word widths on each channel
`define CMD_WIDTH 64
`define RSP_WIDTH 32

// Command fields
`define CMD_OP_WIDTH 4
`define ADDR_WIDTH 12
`define CMD_DATA_WIDTH 48

// Response fields
`define RSP_STATUS_WIDTH 4
`define RSP_DATA_WIDTH 16

// Flops per level synchronizer
`define SYNC_STAGES 2

`endif

/* design/mem_layout_pkg.sv */
`include "cdc_defs.svh"

package mem_layout_pkg;

	typedef logic [`CMD_OP_WIDTH-1:0] cmd_op_t;
	typedef logic [`ADDR_WIDTH-1:0] addr_t;
	typedef logic [`CMD_DATA_WIDTH-1:0] cmd_data_t;

	// Processor to DAC command, opcode in the top bits
	typedef struct packed
	{
		cmd_op_t op;
		addr_t addr;
		cmd_data_t data;
	} ps_cmd_t;

	typedef logic [`RSP_STATUS_WIDTH-1:0] rsp_status_t;
	typedef logic [`RSP_DATA_WIDTH-1:0] rsp_data_t;

	// DAC to processor response
	// Tag echoes the address of the command being answered
	typedef struct packed
	{
		rsp_status_t status;
		addr_t tag;
		rsp_data_t data;
	} dac_rsp_t;

endpackage

/* design/ps_dac_cdc.sv */
`default_nettype none
`include "cdc_defs.svh"

module ps_dac_cdc (
	input  logic                     ps_clk,
	input  logic                     dac_clk,
	input  logic                     rst_n,
	input  mem_layout_pkg::ps_cmd_t  ps_cmd_in,
	input  logic                     ps_cmd_valid_in,
	output logic                     ps_cmd_transfer_rdy,
	output logic                     ps_cmd_transfer_done,
	output mem_layout_pkg::ps_cmd_t  ps_cmd_out,
	output logic                     ps_cmd_valid_out,
	input  mem_layout_pkg::dac_rsp_t dac_resp_in,
	input  logic                     dac_resp_valid_in,
	output logic                     dac_resp_transfer_rdy,
	output logic                     dac_resp_transfer_done,
	output mem_layout_pkg::dac_rsp_t dac_resp_out,
	output logic                     dac_resp_valid_out
);

	// Commands, ps to dac
	cdc_channel #(
		.WIDTH(`CMD_WIDTH)
	) i_cmd_channel (
		.src_clk  (ps_clk),
		.dst_clk  (dac_clk),
		.rst_n    (rst_n),
		.data_in  (ps_cmd_in),
		.valid_in (ps_cmd_valid_in),
		.rdy      (ps_cmd_transfer_rdy),
		.done     (ps_cmd_transfer_done),
		.data_out (ps_cmd_out),
		.valid_out(ps_cmd_valid_out)
	);

	// Responses, dac to ps
	cdc_channel #(
		.WIDTH(`RSP_WIDTH)
	) i_rsp_channel (
		.src_clk  (dac_clk),
		.dst_clk  (ps_clk),
		.rst_n    (rst_n),
		.data_in  (dac_resp_in),
		.valid_in (dac_resp_valid_in),
		.rdy      (dac_resp_transfer_rdy),
		.done     (dac_resp_transfer_done),
		.data_out (dac_resp_out),
		.valid_out(dac_resp_valid_out)
	);

endmodule

`default_nettype wire

/* design/xfer_dst.sv */
`default_nettype none

module xfer_dst #(
	parameter int WIDTH = 32
) (
	input  logic             clk,
	input  logic             rst_n,
	input  logic             req_sync,
	input  logic [WIDTH-1:0] data_hold,
	output logic [WIDTH-1:0] data_out,
	output logic             valid_out,
	output logic             ack
);

	xfer_pkg::dst_state_e state;
	logic capture;

	// data_hold is frozen while req is high
	assign capture = req_sync && (state == xfer_pkg::WAIT_REQ);

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			state <= xfer_pkg::WAIT_REQ;
		end
		else
		begin
			case (state)
				xfer_pkg::WAIT_REQ:
				begin
					if (req_sync)
						state <= xfer_pkg::ACK_HIGH;
				end
				xfer_pkg::ACK_HIGH:
				begin
					if (!req_sync)
						state <= xfer_pkg::WAIT_REQ;
				end
				default:
				begin
					state <= xfer_pkg::WAIT_REQ;
				end
			endcase
		end
	end

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			data_out <= '0;
			valid_out <= 1'b0;
		end
		else
		begin
			valid_out <= capture;
			// Output holds until the next transfer
			if (capture)
				data_out <= data_hold;
		end
	end

	// Single-bit state flop, no glitch on the crossing
	assign ack = (state == xfer_pkg::ACK_HIGH);

endmodule

`default_nettype wire

/* design/xfer_pkg.sv */
package xfer_pkg;

	// Sending half of the four-phase handshake
	typedef enum logic [1:0]
	{
		IDLE,
		REQ_HIGH,
		REQ_LOW
	} src_state_e;

	// Receiving half, state doubles as ack
	typedef enum logic
	{
		WAIT_REQ,
		ACK_HIGH
	} dst_state_e;

	// Handshake wires between the two endpoints
	typedef struct packed
	{
		logic req;
		logic ack;
	} hs_t;

endpackage

/* design/xfer_src.sv */
`default_nettype none

module xfer_src #(
	parameter int WIDTH = 32
) (
	input  logic             clk,
	input  logic             rst_n,
	input  logic [WIDTH-1:0] data_in,
	input  logic             valid_in,
	input  logic             ack_sync,
	output logic             req,
	output logic [WIDTH-1:0] data_hold,
	output logic             rdy,
	output logic             done
);

	xfer_pkg::src_state_e state;
	xfer_pkg::src_state_e state_next;
	logic accept;

	// Pulses while busy are dropped
	assign accept = valid_in && (state == xfer_pkg::IDLE);

	always_comb
	begin
		state_next = state;
		case (state)
			xfer_pkg::IDLE:
			begin
				if (accept)
					state_next = xfer_pkg::REQ_HIGH;
			end
			xfer_pkg::REQ_HIGH:
			begin
				// Hold req until ack has made it through the synchronizer
				if (ack_sync)
					state_next = xfer_pkg::REQ_LOW;
			end
			xfer_pkg::REQ_LOW:
			begin
				if (!ack_sync)
					state_next = xfer_pkg::IDLE;
			end
			default:
			begin
				state_next = xfer_pkg::IDLE;
			end
		endcase
	end

	// req leaves the domain, so it comes straight from a flop
	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			state <= xfer_pkg::IDLE;
			req <= 1'b0;
			rdy <= 1'b1;
			done <= 1'b0;
		end
		else
		begin
			state <= state_next;
			req <= (state_next == xfer_pkg::REQ_HIGH);
			rdy <= (state_next == xfer_pkg::IDLE);
			done <= (state == xfer_pkg::REQ_LOW) && (state_next == xfer_pkg::IDLE);
		end
	end

	// Loaded on acceptance only, so stable for the whole handshake
	always_ff @(posedge clk)
	begin
		if (accept)
			data_hold <= data_in;
	end

endmodule

`default_nettype wire

/* list.f */
+incdir+design
design/mem_layout_pkg.sv
design/xfer_pkg.sv
design/bit_sync.sv
design/xfer_src.sv
design/xfer_dst.sv
design/cdc_channel.sv
design/ps_dac_cdc.sv
verification/cdc_props.sv
verification/cdc_tb.sv

/* verification/cdc_props.sv */
module cdc_props #(
	parameter int WIDTH = 32
) (
	input logic             src_clk,
	input logic             dst_clk,
	input logic             src_rst_n,
	input logic             dst_rst_n,
	input logic             req,
	input logic             ack,
	input logic [WIDTH-1:0] data_hold,
	input logic             done,
	input logic             valid_out
);

	timeunit 1ns;
	timeprecision 1ps;

	// Four-phase ordering
	req_after_ack_low: assert property (@(posedge src_clk) disable iff (!src_rst_n)
		$rose(req) |-> !ack)
		else $error("req rose while ack was still high");

	ack_after_req_high: assert property (@(posedge dst_clk) disable iff (!dst_rst_n)
		$rose(ack) |-> req)
		else $error("ack rose while req was low");

	// Destination samples this across the domain
	hold_stable: assert property (@(posedge src_clk) disable iff (!src_rst_n)
		req |=> $stable(data_hold))
		else $error("data_hold changed while req was high");

	done_one_cycle: assert property (@(posedge src_clk) disable iff (!src_rst_n)
		done |=> !done)
		else $error("done lasted more than one cycle");

	valid_one_cycle: assert property (@(posedge dst_clk) disable iff (!dst_rst_n)
		valid_out |=> !valid_out)
		else $error("valid_out lasted more than one cycle");

endmodule

bind cdc_channel cdc_props #(
	.WIDTH(WIDTH)
) i_cdc_props (
	.src_clk  (src_clk),
	.dst_clk  (dst_clk),
	.src_rst_n(src_rst_n),
	.dst_rst_n(dst_rst_n),
	.req      (hs.req),
	.ack      (hs.ack),
	.data_hold(data_hold),
	.done     (done),
	.valid_out(valid_out)
);

/* verification/cdc_tb.sv */
`include "cdc_defs.svh"

module cdc_tb;

	timeunit 1ns;
	timeprecision 1ps;

	localparam int DIR_CMD = 0;
	localparam int DIR_RSP = 1;
	localparam int DIR_BOTH = 2;
	localparam int NUM_TESTS = 6;
	localparam int MAX_WORDS = 16;
	localparam int TIMEOUT_CYCLES = 200;
	localparam int QUIET_CYCLES = 24;

	// One row per test
	// A gap of -1 draws every gap from the LFSR
	typedef struct packed
	{
		int dir;
		int words;
		int gap;
		bit extra;
	} row_t;

	typedef struct packed
	{
		logic rdy;
		logic done;
		logic valid;
	} flags_t;

	logic ps_clk = 1'b0;
	logic dac_clk = 1'b0;
	logic rst_n;
	mem_layout_pkg::ps_cmd_t ps_cmd_in;
	logic ps_cmd_valid_in;
	logic ps_cmd_transfer_rdy;
	logic ps_cmd_transfer_done;
	mem_layout_pkg::ps_cmd_t ps_cmd_out;
	logic ps_cmd_valid_out;
	mem_layout_pkg::dac_rsp_t dac_resp_in;
	logic dac_resp_valid_in;
	logic dac_resp_transfer_rdy;
	logic dac_resp_transfer_done;
	mem_layout_pkg::dac_rsp_t dac_resp_out;
	logic dac_resp_valid_out;

	row_t table_rows [NUM_TESTS];
	string table_names [NUM_TESTS];
	logic [`CMD_WIDTH-1:0] exp_words [2][MAX_WORDS];
	// Last word delivered on each channel, zero out of reset
	logic [`CMD_WIDTH-1:0] last_word [2];
	int gap_len [2][MAX_WORDS];
	int delivered [2];
	logic [31:0] lfsr = 32'he8f5_b6b0;
	int errors = 0;
	int failed_tests = 0;

	ps_dac_cdc i_ps_dac_cdc (
		.ps_clk                (ps_clk),
		.dac_clk               (dac_clk),
		.rst_n                 (rst_n),
		.ps_cmd_in             (ps_cmd_in),
		.ps_cmd_valid_in       (ps_cmd_valid_in),
		.ps_cmd_transfer_rdy   (ps_cmd_transfer_rdy),
		.ps_cmd_transfer_done  (ps_cmd_transfer_done),
		.ps_cmd_out            (ps_cmd_out),
		.ps_cmd_valid_out      (ps_cmd_valid_out),
		.dac_resp_in           (dac_resp_in),
		.dac_resp_valid_in     (dac_resp_valid_in),
		.dac_resp_transfer_rdy (dac_resp_transfer_rdy),
		.dac_resp_transfer_done(dac_resp_transfer_done),
		.dac_resp_out          (dac_resp_out),
		.dac_resp_valid_out    (dac_resp_valid_out)
	);

	initial
	begin
		forever #20 dac_clk = ~dac_clk;
	end

	initial
	begin
		forever #14 ps_clk = ~ps_clk;
	end

	// Taps 32, 22, 2, 1
	function automatic logic lfsr_step();
		logic fb;
		fb = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
		lfsr = {lfsr[30:0], fb};
		return fb;
	endfunction

	function automatic logic [63:0] take_bits(input int n);
		logic [63:0] bits;
		bits = '0;
		for (int i = 0; i < n; i++)
			bits = {bits[62:0], lfsr_step()};
		return bits;
	endfunction

	function automatic logic [`CMD_WIDTH-1:0] make_word(input int dir);
		mem_layout_pkg::ps_cmd_t cmd;
		mem_layout_pkg::dac_rsp_t rsp;
		if (dir == DIR_CMD)
		begin
			cmd.op = mem_layout_pkg::cmd_op_t'(take_bits(4));
			cmd.addr = mem_layout_pkg::addr_t'(take_bits(12));
			cmd.data = mem_layout_pkg::cmd_data_t'(take_bits(48));
			return cmd;
		end
		rsp.status = mem_layout_pkg::rsp_status_t'(take_bits(4));
		rsp.tag = mem_layout_pkg::addr_t'(take_bits(12));
		rsp.data = mem_layout_pkg::rsp_data_t'(take_bits(16));
		return {{(`CMD_WIDTH - `RSP_WIDTH){1'b0}}, rsp};
	endfunction

	function automatic flags_t get_flags(input int dir);
		flags_t f;
		if (dir == DIR_CMD)
			f = '{ps_cmd_transfer_rdy, ps_cmd_transfer_done, ps_cmd_valid_out};
		else
			f = '{dac_resp_transfer_rdy, dac_resp_transfer_done, dac_resp_valid_out};
		return f;
	endfunction

	function automatic logic [`CMD_WIDTH-1:0] out_word(input int dir);
		if (dir == DIR_CMD)
			return ps_cmd_out;
		return {{(`CMD_WIDTH - `RSP_WIDTH){1'b0}}, dac_resp_out};
	endfunction

	task automatic tick_src(input int dir);
		if (dir == DIR_CMD)
			@(negedge ps_clk);
		else
			@(negedge dac_clk);
	endtask

	task automatic tick_dst(input int dir);
		if (dir == DIR_CMD)
			@(negedge dac_clk);
		else
			@(negedge ps_clk);
	endtask

	task automatic drive_input(input int dir, input logic valid,
		input logic [`CMD_WIDTH-1:0] word);
		if (dir == DIR_CMD)
		begin
			ps_cmd_in = word;
			ps_cmd_valid_in = valid;
		end
		else
		begin
			dac_resp_in = word[`RSP_WIDTH-1:0];
			dac_resp_valid_in = valid;
		end
	endtask

	task automatic report_error(input string msg);
		$display("%s", msg);
		errors++;
	endtask

	task automatic check_value(input string name, input logic [`CMD_WIDTH-1:0] expected,
		input logic [`CMD_WIDTH-1:0] actual);
		assert (actual === expected)
		else
		begin
			$display("[FAIL] %s: expected %h, actual %h", name, expected, actual);
			errors++;
		end
	endtask

	task automatic send_words(input int dir, input string name, input int n, input bit extra);
		flags_t f;
		int waited;
		for (int i = 0; i < n; i++)
		begin
			repeat (gap_len[dir][i])
				tick_src(dir);
			waited = 0;
			do
			begin
				tick_src(dir);
				f = get_flags(dir);
				waited++;
			end
			while (!f.rdy && waited < TIMEOUT_CYCLES);
			if (!f.rdy)
			begin
				report_error({name, ": rdy stayed low until the timeout"});
				return;
			end
			drive_input(dir, 1'b1, exp_words[dir][i]);
			tick_src(dir);
			// Inverted input shows the source keeps its own copy
			drive_input(dir, extra, ~exp_words[dir][i]);
			f = get_flags(dir);
			assert (!f.rdy)
				else report_error({name, ": rdy still high after a word was accepted"});
			tick_src(dir);
			drive_input(dir, 1'b0, ~exp_words[dir][i]);
			waited = 0;
			f = get_flags(dir);
			while (!f.done && waited < TIMEOUT_CYCLES)
			begin
				tick_src(dir);
				f = get_flags(dir);
				waited++;
			end
			if (!f.done)
			begin
				report_error({name, ": no done pulse before the timeout"});
				return;
			end
			assert (f.rdy)
				else report_error({name, ": rdy low while done pulsed"});
			assert (delivered[dir] == i + 1)
				else report_error({name, ": done pulsed without a matching valid_out"});
		end
	endtask

	task automatic recv_words(input int dir, input string name, input int n);
		flags_t f;
		int waited;
		for (int i = 0; i < n; i++)
		begin
			waited = 0;
			do
			begin
				tick_dst(dir);
				f = get_flags(dir);
				waited++;
				// Output holds the previous word until the pulse
				if (!f.valid)
					check_value(name, last_word[dir], out_word(dir));
			end
			while (!f.valid && waited < TIMEOUT_CYCLES);
			if (!f.valid)
			begin
				report_error({name, ": no valid_out pulse before the timeout"});
				return;
			end
			check_value(name, exp_words[dir][i], out_word(dir));
			delivered[dir]++;
			last_word[dir] = exp_words[dir][i];
		end
		// Busy pulses must not turn into extra words
		repeat (QUIET_CYCLES)
		begin
			tick_dst(dir);
			f = get_flags(dir);
			assert (!f.valid)
				else report_error({name, ": valid_out pulsed with no word outstanding"});
		end
	endtask

	task automatic report_test(input string name, input int errors_before);
		if (errors == errors_before)
			$display("test %-16s ok", name);
		else
		begin
			$display("test %-16s %0d errors", name, errors - errors_before);
			failed_tests++;
		end
	endtask

	task automatic run_test(input int t);
		row_t row;
		int errors_before;
		row = table_rows[t];
		errors_before = errors;
		delivered[DIR_CMD] = 0;
		delivered[DIR_RSP] = 0;
		for (int d = DIR_CMD; d <= DIR_RSP; d++)
			for (int i = 0; i < row.words; i++)
			begin
				exp_words[d][i] = make_word(d);
				gap_len[d][i] = (row.gap < 0) ? int'(take_bits(3)) : row.gap;
			end
		fork
			if (row.dir != DIR_RSP)
				send_words(DIR_CMD, table_names[t], row.words, row.extra);
			if (row.dir != DIR_RSP)
				recv_words(DIR_CMD, table_names[t], row.words);
			if (row.dir != DIR_CMD)
				send_words(DIR_RSP, table_names[t], row.words, row.extra);
			if (row.dir != DIR_CMD)
				recv_words(DIR_RSP, table_names[t], row.words);
		join
		report_test(table_names[t], errors_before);
	endtask

	task automatic load_table();
		table_rows[0] = '{DIR_CMD, 1, 0, 1'b0};
		table_names[0] = "cmd_single";
		table_rows[1] = '{DIR_CMD, 6, 0, 1'b0};
		table_names[1] = "cmd_burst";
		table_rows[2] = '{DIR_RSP, 6, 3, 1'b0};
		table_names[2] = "rsp_burst";
		table_rows[3] = '{DIR_CMD, 4, 1, 1'b1};
		table_names[3] = "cmd_busy_pulse";
		table_rows[4] = '{DIR_RSP, 4, 0, 1'b1};
		table_names[4] = "rsp_busy_pulse";
		table_rows[5] = '{DIR_BOTH, 8, -1, 1'b0};
		table_names[5] = "mixed_random";
	endtask

	initial
	begin
		rst_n = 1'b0;
		ps_cmd_in = '0;
		ps_cmd_valid_in = 1'b0;
		dac_resp_in = '0;
		dac_resp_valid_in = 1'b0;
		last_word[DIR_CMD] = '0;
		last_word[DIR_RSP] = '0;
		load_table();
		repeat (4)
			@(negedge dac_clk);
		rst_n = 1'b1;
		repeat (4)
			@(negedge dac_clk);
		check_value("reset_state", '0, out_word(DIR_CMD));
		check_value("reset_state", '0, out_word(DIR_RSP));
		// rdy, done and valid of each channel
		check_value("reset_state", 64'h24, {58'h0, get_flags(DIR_CMD), get_flags(DIR_RSP)});
		report_test("reset_state", 0);
		for (int t = 0; t < NUM_TESTS; t++)
			run_test(t);
		$display("%0d tests run, %0d failed, %0d errors", NUM_TESTS + 1, failed_tests, errors);
		if (errors == 0)
			$display("*** TEST PASSED ***");
		else
			$display("*** TEST FAILED ***");
		$finish;
	end

endmodule
